/* bench/cpri_rx_buffer_sva.sv */
// Protocol checks for the CPRI uplink receive buffer
// Bound to the top level, watches status levels and output markers
`timescale 1ns/1ns

module cpri_rx_buffer_sva (
    input logic                           i_clk,
    input logic                           i_reset,
    input logic                           i_rd_en,
    input logic                           i_rready,
    input logic                           o_rd_vld,
    input logic                           o_tready,
    input logic                           o_tvalid,
    input logic                           o_tx_last,
    input logic                           o_symb_eop,
    input logic [cpri_rx_pkg::CHIP_W-1:0] o_tx_addr
);

    logic        rd_acc;
    int unsigned fail_count = 0;

    // Read accepted by the sequencer on this edge
    assign rd_acc = i_rd_en & i_rready & o_rd_vld;

    a_status_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_tready && o_rd_vld))
        else begin
            fail_count++;
            $error("o_tready and o_rd_vld high together");
        end

    a_read_to_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        rd_acc |-> ##2 o_tvalid)
        else begin
            fail_count++;
            $error("accepted read not followed by o_tvalid two cycles later");
        end

    a_valid_from_read: assert property (@(posedge i_clk) disable iff (i_reset)
        o_tvalid |-> $past(rd_acc, 2))
        else begin
            fail_count++;
            $error("o_tvalid without an accepted read two cycles earlier");
        end

    a_eop_in_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_symb_eop |-> o_tvalid)
        else begin
            fail_count++;
            $error("o_symb_eop outside o_tvalid");
        end

    a_last_at_chip_end: assert property (@(posedge i_clk) disable iff (i_reset)
        o_tx_last |-> (o_tx_addr == cpri_rx_pkg::CHIP_WORDS - 1))
        else begin
            fail_count++;
            $error("o_tx_last away from chip address 95");
        end

endmodule

bind cpri_rx_buffer cpri_rx_buffer_sva u_sva (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rd_en    (i_rd_en),
    .i_rready   (i_rready),
    .o_rd_vld   (o_rd_vld),
    .o_tready   (o_tready),
    .o_tvalid   (o_tvalid),
    .o_tx_last  (o_tx_last),
    .o_symb_eop (o_symb_eop),
    .o_tx_addr  (o_tx_addr)
);

/* bench/tb_cpri_rx_buffer.sv */
// Testbench for the CPRI uplink receive buffer
// Sends LFSR filled bursts with chosen slots, reads the stored
// symbols back and checks every output word against a model
`timescale 1ns/1ns

module tb_cpri_rx_buffer;

    localparam int WORDS      = cpri_rx_pkg::SYMBOL_WORDS;
    localparam int CHIP       = cpri_rx_pkg::CHIP_WORDS;
    localparam int CLK_PERIOD = 40;
    localparam int GAP        = 4;
    // Twelve bursts, seven steady reads, one read at about half rate
    localparam int RUN_CYCLES = 12 * (WORDS + GAP + 1) + 7 * (WORDS + 6) + 4 * WORDS + 2000;

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic [63:0] i_rx_data;
    logic        i_rvalid;
    logic        i_rd_en;
    logic        i_rready;
    logic        o_rd_vld;
    logic        o_tready;
    logic [63:0] o_tx_data;
    logic [6:0]  o_tx_addr;
    logic        o_tx_last;
    logic        o_symb_eop;
    logic        o_tvalid;
    logic [63:0] o_fft_agc;

    logic [31:0] lfsr = 32'h1c0e0835;
    int          errors = 0;
    int          checks = 0;
    bit          model_full = 1'b0;
    logic [63:0] last_agc;

    // Expected output words, oldest first
    logic [63:0] exp_data [$];
    logic [6:0]  exp_addr [$];
    logic        exp_last [$];
    logic        exp_eop [$];
    logic [63:0] exp_agc [$];

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    cpri_rx_buffer u_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_data  (i_rx_data),
        .i_rvalid   (i_rvalid),
        .i_rd_en    (i_rd_en),
        .i_rready   (i_rready),
        .o_rd_vld   (o_rd_vld),
        .o_tready   (o_tready),
        .o_tx_data  (o_tx_data),
        .o_tx_addr  (o_tx_addr),
        .o_tx_last  (o_tx_last),
        .o_symb_eop (o_symb_eop),
        .o_tvalid   (o_tvalid),
        .o_fft_agc  (o_fft_agc)
    );

    // ----------------------------------------------------------
    // Stimulus source and reference model
    // ----------------------------------------------------------
    // Galois LFSR, one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Uplink slots: slot mod 5 is 4, below 80
    function automatic bit slot_kept(input int slot);
        return (slot < 80) && (slot % 5 == 4);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_value("o_tvalid", 64'd0, o_tvalid);
        check_value("o_rd_vld", 64'd0, o_rd_vld);
        check_value("o_tx_last", 64'd0, o_tx_last);
        check_value("o_symb_eop", 64'd0, o_symb_eop);
        check_value("o_tready", 64'd1, o_tready);
    endtask

    // One burst: header word then random sample words
    task automatic send_burst(input int slot, input int symb);
        logic [63:0] words [WORDS];
        bit          kept;
        int          k;
        kept = slot_kept(slot) && !model_full;
        for (k = 0; k < WORDS; k++) begin
            words[k] = take_bits(64);
        end
        words[0][18:12] = slot[6:0];
        words[0][11:8]  = symb[3:0];
        words[0][7:0]   = 8'h00;
        if (kept) begin
            last_agc = {words[cpri_rx_pkg::AGC_ODD_ADDR][63:32],
                        words[cpri_rx_pkg::AGC_EVEN_ADDR][63:32]};
            for (k = 0; k < WORDS; k++) begin
                exp_data.push_back(words[k]);
                exp_addr.push_back(7'(k % CHIP));
                exp_last.push_back((k % CHIP) == CHIP - 1);
                exp_eop.push_back(k == WORDS - 1);
                exp_agc.push_back(last_agc);
            end
            model_full = 1'b1;
        end
        for (k = 0; k < WORDS; k++) begin
            @(negedge i_clk);
            i_rvalid  = 1'b1;
            i_rx_data = words[k];
        end
        @(negedge i_clk);
        i_rvalid  = 1'b0;
        i_rx_data = '0;
        repeat (GAP) @(negedge i_clk);
    endtask

    // Reads count words, optionally with random pauses on both strobes
    task automatic read_symbol(input int count, input bit paused);
        int done_reads;
        done_reads = 0;
        while (done_reads < count) begin
            @(negedge i_clk);
            i_rd_en  = paused ? (take_bits(2) != 0) : 1'b1;
            i_rready = paused ? (take_bits(2) != 0) : 1'b1;
            if (i_rd_en && i_rready && o_rd_vld) begin
                done_reads++;
            end
        end
        @(negedge i_clk);
        i_rd_en  = 1'b0;
        i_rready = 1'b0;
        repeat (4) @(negedge i_clk);
        if (count == WORDS) begin
            model_full = 1'b0;
            if (exp_data.size() != 0) begin
                $display("%0d expected output words never came out by %0t",
                         exp_data.size(), $time);
                errors++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_count);
        $display("Test %0d %s: %0d errors", num, name, err_count);
    endtask

    // ----------------------------------------------------------
    // Output comparison
    // ----------------------------------------------------------
    always @(negedge i_clk) begin
        if (!i_reset && o_tvalid) begin
            if (exp_data.size() == 0) begin
                $display("Output word at %0t while no stored symbol was expected", $time);
                errors++;
            end else begin
                check_value("o_tx_data", exp_data.pop_front(), o_tx_data);
                check_value("o_tx_addr", exp_addr.pop_front(), o_tx_addr);
                check_value("o_tx_last", exp_last.pop_front(), o_tx_last);
                check_value("o_symb_eop", exp_eop.pop_front(), o_symb_eop);
                check_value("o_fft_agc", exp_agc.pop_front(), o_fft_agc);
            end
        end
    end

    initial begin
        repeat (RUN_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
        $display("test failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int mark;
        int reset_errs;
        i_reset   = 1'b1;
        i_rvalid  = 1'b0;
        i_rx_data = '0;
        i_rd_en   = 1'b0;
        i_rready  = 1'b0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        mark    = errors;
        check_idle();
        reset_errs = errors - mark;

        mark = errors;
        send_burst(4, 0);
        read_symbol(WORDS, 1'b0);
        report_test(1, "uplink slot readout", errors - mark);

        mark = errors;
        send_burst(3, 1);
        check_value("o_tready", 64'd1, o_tready);
        send_burst(5, 2);
        check_value("o_tready", 64'd1, o_tready);
        send_burst(84, 3);
        check_value("o_tready", 64'd1, o_tready);
        check_value("o_rd_vld", 64'd0, o_rd_vld);
        report_test(2, "non-uplink slots dropped", errors - mark);

        mark = errors;
        send_burst(9, 4);
        check_value("o_rd_vld", 64'd1, o_rd_vld);
        check_value("o_tready", 64'd0, o_tready);
        check_value("o_fft_agc", last_agc, o_fft_agc);
        read_symbol(WORDS, 1'b0);
        send_burst(14, 5);
        check_value("o_fft_agc", last_agc, o_fft_agc);
        read_symbol(WORDS, 1'b0);
        report_test(3, "AGC pair per symbol", errors - mark);

        mark = errors;
        send_burst(19, 6);
        read_symbol(WORDS, 1'b1);
        report_test(4, "read with random pauses", errors - mark);

        // Middle burst arrives while the buffer is full
        mark = errors;
        send_burst(24, 7);
        send_burst(29, 8);
        check_value("o_rd_vld", 64'd1, o_rd_vld);
        check_value("o_tready", 64'd0, o_tready);
        read_symbol(WORDS, 1'b0);
        send_burst(34, 9);
        read_symbol(WORDS, 1'b0);
        report_test(5, "burst dropped while full", errors - mark);

        // Reset in the middle of a readout, then a clean symbol
        mark = errors;
        send_burst(39, 10);
        read_symbol(100, 1'b0);
        @(negedge i_clk);
        i_reset = 1'b1;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        check_idle();
        exp_data.delete();
        exp_addr.delete();
        exp_last.delete();
        exp_eop.delete();
        exp_agc.delete();
        model_full = 1'b0;
        send_burst(44, 11);
        read_symbol(WORDS, 1'b0);
        report_test(6, "state after reset", errors - mark + reset_errs);

        if (u_dut.u_sva.fail_count != 0) begin
            $display("%0d protocol assertion failures reported", u_dut.u_sva.fail_count);
            errors = errors + u_dut.u_sva.fail_count;
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/chip_read_sequencer.sv */
// Chip read sequencer
// Accepts consumer read strobes while a symbol is stored and
// steps through the symbol, numbering words in chips of 96
// and flagging the chip end and the final word of the symbol
`timescale 1ns/1ns

module chip_read_sequencer (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               i_rd_en,
    input  logic                               i_rready,
    input  logic                               i_buf_full,
    output logic                               o_rd_en,
    output logic [cpri_rx_pkg::ADDR_W-1:0]     o_rd_addr,
    output logic [cpri_rx_pkg::CHIP_W-1:0]     o_chip_addr,
    output logic                               o_chip_last,
    output logic                               o_rd_done
);

    localparam logic [cpri_rx_pkg::ADDR_W-1:0] LAST_ADDR =
        cpri_rx_pkg::ADDR_W'(cpri_rx_pkg::SYMBOL_WORDS - 1);
    localparam logic [cpri_rx_pkg::CHIP_W-1:0] LAST_CHIP =
        cpri_rx_pkg::CHIP_W'(cpri_rx_pkg::CHIP_WORDS - 1);

    logic rd_acc;
    logic addr_last;

    // ------------------------------------------------------------
    // Read acceptance
    // ------------------------------------------------------------
    // Nothing is read unless a whole symbol is stored
    assign rd_acc    = i_rd_en & i_rready & i_buf_full;
    assign addr_last = (o_rd_addr == LAST_ADDR);

    assign o_rd_en     = rd_acc;
    assign o_rd_done   = rd_acc & addr_last;
    assign o_chip_last = (o_chip_addr == LAST_CHIP);

    // ------------------------------------------------------------
    // Symbol and chip counters
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rd_addr <= '0;
        end else if (rd_acc) begin
            if (addr_last) begin
                o_rd_addr <= '0;
            end else begin
                o_rd_addr <= o_rd_addr + 1'b1;
            end
        end
    end

    // Chip numbering restarts with every symbol
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_chip_addr <= '0;
        end else if (rd_acc) begin
            if (addr_last || o_chip_last) begin
                o_chip_addr <= '0;
            end else begin
                o_chip_addr <= o_chip_addr + 1'b1;
            end
        end
    end

endmodule

/* verilog/cpri_rx_buffer.sv */
// CPRI uplink receive buffer, top level
// Uplink bursts are filtered and written into a one-symbol
// buffer, then read out in chips of 96 words with the AGC pair
`timescale 1ns/1ns

module cpri_rx_buffer (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic [cpri_rx_pkg::WORD_W-1:0]     i_rx_data,
    input  logic                               i_rvalid,
    input  logic                               i_rd_en,
    input  logic                               i_rready,
    output logic                               o_rd_vld,
    output logic                               o_tready,
    output logic [cpri_rx_pkg::WORD_W-1:0]     o_tx_data,
    output logic [cpri_rx_pkg::CHIP_W-1:0]     o_tx_addr,
    output logic                               o_tx_last,
    output logic                               o_symb_eop,
    output logic                               o_tvalid,
    output logic [63:0]                        o_fft_agc
);

    logic                           wr_en;
    logic [cpri_rx_pkg::ADDR_W-1:0] wr_addr;
    logic [cpri_rx_pkg::WORD_W-1:0] wr_data;
    logic                           wr_done;
    logic                           buf_full;
    logic                           rd_en;
    logic [cpri_rx_pkg::ADDR_W-1:0] rd_addr;
    logic [cpri_rx_pkg::CHIP_W-1:0] chip_addr;
    logic                           chip_last;
    logic                           rd_done;

    // Status towards producer and consumer
    assign o_rd_vld = buf_full;
    assign o_tready = ~buf_full;

    uplink_symbol_writer u_writer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_data  (i_rx_data),
        .i_rvalid   (i_rvalid),
        .i_buf_full (buf_full),
        .o_wr_en    (wr_en),
        .o_wr_addr  (wr_addr),
        .o_wr_data  (wr_data),
        .o_wr_done  (wr_done)
    );

    chip_read_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rd_en     (i_rd_en),
        .i_rready    (i_rready),
        .i_buf_full  (buf_full),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .o_chip_addr (chip_addr),
        .o_chip_last (chip_last),
        .o_rd_done   (rd_done)
    );

    symbol_buffer u_buffer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_wr_done   (wr_done),
        .i_rd_en     (rd_en),
        .i_rd_addr   (rd_addr),
        .i_chip_addr (chip_addr),
        .i_chip_last (chip_last),
        .i_rd_done   (rd_done),
        .o_buf_full  (buf_full),
        .o_tx_data   (o_tx_data),
        .o_tx_addr   (o_tx_addr),
        .o_tx_last   (o_tx_last),
        .o_symb_eop  (o_symb_eop),
        .o_tvalid    (o_tvalid),
        .o_fft_agc   (o_fft_agc)
    );

endmodule

/* verilog/cpri_rx_pkg.sv */
// CPRI uplink receive buffer shared definitions
// Frame geometry, uplink slot rule constants and the
// two decodings of a 64-bit burst word
package cpri_rx_pkg;

    // ------------------------------------------------------------
    // Word and buffer geometry
    // ------------------------------------------------------------
    localparam int unsigned WORD_W       = 64;
    localparam int unsigned SYMBOL_WORDS = 3168;
    localparam int unsigned ADDR_W       = 12;

    // Read side chip grouping, 33 chips per symbol
    localparam int unsigned CHIP_WORDS   = 96;
    localparam int unsigned CHIP_W       = 7;

    // ------------------------------------------------------------
    // Header fields and uplink slot rule
    // ------------------------------------------------------------
    localparam int unsigned SLOT_W        = 7;
    localparam int unsigned SYMB_W        = 4;
    localparam int unsigned UPLINK_PERIOD = 5;
    localparam int unsigned UPLINK_PHASE  = 4;
    localparam int unsigned SLOT_LIMIT    = 80;

    // Word positions holding the AGC values
    localparam int unsigned AGC_EVEN_ADDR = 4;
    localparam int unsigned AGC_ODD_ADDR  = 1636;

    // ------------------------------------------------------------
    // Burst word views
    // ------------------------------------------------------------
    // Header word, first word of every burst
    typedef struct packed {
        logic [WORD_W-SLOT_W-SYMB_W-9:0] rsvd_hi;
        logic [SLOT_W-1:0]               slot;
        logic [SYMB_W-1:0]               symb;
        logic [7:0]                      rsvd_lo;
    } burst_hdr_t;

    // Sample word, AGC rides in the upper half
    typedef struct packed {
        logic [WORD_W/2-1:0] agc;
        logic [WORD_W/2-1:0] sample;
    } burst_smp_t;

    typedef union packed {
        burst_hdr_t hdr;
        burst_smp_t smp;
    } burst_word_u;

endpackage

/* verilog/symbol_buffer.sv */
// Symbol buffer
// One-symbol RAM between the uplink writer and the chip read
// sequencer. Tracks the full state, captures the AGC pair from
// the write stream and aligns read markers with RAM data so all
// outputs leave from one register stage
`timescale 1ns/1ns

module symbol_buffer (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               i_wr_en,
    input  logic [cpri_rx_pkg::ADDR_W-1:0]     i_wr_addr,
    input  logic [cpri_rx_pkg::WORD_W-1:0]     i_wr_data,
    input  logic                               i_wr_done,
    input  logic                               i_rd_en,
    input  logic [cpri_rx_pkg::ADDR_W-1:0]     i_rd_addr,
    input  logic [cpri_rx_pkg::CHIP_W-1:0]     i_chip_addr,
    input  logic                               i_chip_last,
    input  logic                               i_rd_done,
    output logic                               o_buf_full,
    output logic [cpri_rx_pkg::WORD_W-1:0]     o_tx_data,
    output logic [cpri_rx_pkg::CHIP_W-1:0]     o_tx_addr,
    output logic                               o_tx_last,
    output logic                               o_symb_eop,
    output logic                               o_tvalid,
    output logic [63:0]                        o_fft_agc
);

    logic [cpri_rx_pkg::WORD_W-1:0] mem [cpri_rx_pkg::SYMBOL_WORDS];

    cpri_rx_pkg::burst_word_u       wr_word;
    logic [31:0]                    agc_even;
    logic [31:0]                    agc_odd;

    logic [cpri_rx_pkg::WORD_W-1:0] rd_data_q;
    logic                           rd_vld_q;
    logic [cpri_rx_pkg::CHIP_W-1:0] chip_addr_q;
    logic                           chip_last_q;
    logic                           eop_q;

    // ------------------------------------------------------------
    // Symbol RAM
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            rd_data_q <= mem[i_rd_addr];
        end
    end

    // Full from last write until last read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_buf_full <= 1'b0;
        end else if (i_wr_done) begin
            o_buf_full <= 1'b1;
        end else if (i_rd_done) begin
            o_buf_full <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // AGC capture
    // ------------------------------------------------------------
    assign wr_word = i_wr_data;

    always_ff @(posedge i_clk) begin
        if (i_wr_en && i_wr_addr == cpri_rx_pkg::ADDR_W'(cpri_rx_pkg::AGC_EVEN_ADDR)) begin
            agc_even <= wr_word.smp.agc;
        end
        if (i_wr_en && i_wr_addr == cpri_rx_pkg::ADDR_W'(cpri_rx_pkg::AGC_ODD_ADDR)) begin
            agc_odd <= wr_word.smp.agc;
        end
    end

    // Pair is published with the completed symbol, odd on top
    always_ff @(posedge i_clk) begin
        if (i_wr_done) begin
            o_fft_agc <= {agc_odd, agc_even};
        end
    end

    // ------------------------------------------------------------
    // Read marker alignment
    // ------------------------------------------------------------
    // Stage 1 runs beside the RAM read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_vld_q    <= 1'b0;
            chip_last_q <= 1'b0;
            eop_q       <= 1'b0;
        end else begin
            rd_vld_q    <= i_rd_en;
            chip_last_q <= i_rd_en & i_chip_last;
            eop_q       <= i_rd_done;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            chip_addr_q <= i_chip_addr;
        end
    end

    // Output register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tvalid   <= 1'b0;
            o_tx_last  <= 1'b0;
            o_symb_eop <= 1'b0;
        end else begin
            o_tvalid   <= rd_vld_q;
            o_tx_last  <= chip_last_q;
            o_symb_eop <= eop_q;
        end
    end

    always_ff @(posedge i_clk) begin
        o_tx_data <= rd_data_q;
        o_tx_addr <= chip_addr_q;
    end

endmodule

/* verilog/uplink_symbol_writer.sv */
// Uplink symbol writer
// Finds the header word of each burst, keeps the burst only for
// uplink slots while the symbol buffer is empty, and turns the
// kept words into buffer write strobes, addresses and a done pulse
`timescale 1ns/1ns

module uplink_symbol_writer (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  cpri_rx_pkg::burst_word_u           i_rx_data,
    input  logic                               i_rvalid,
    input  logic                               i_buf_full,
    output logic                               o_wr_en,
    output logic [cpri_rx_pkg::ADDR_W-1:0]     o_wr_addr,
    output logic [cpri_rx_pkg::WORD_W-1:0]     o_wr_data,
    output logic                               o_wr_done
);

    logic                           rvalid_q;
    logic                           hdr_cycle;
    logic [cpri_rx_pkg::SLOT_W-1:0] hdr_slot;
    logic                           slot_uplink;
    logic                           burst_keep;
    logic                           keep;
    logic [cpri_rx_pkg::ADDR_W-1:0] word_idx;
    logic                           word_last;

    // ------------------------------------------------------------
    // Header detection and slot filter
    // ------------------------------------------------------------
    // Header is the first valid cycle after a gap
    assign hdr_cycle = i_rvalid & ~rvalid_q;
    assign hdr_slot  = i_rx_data.hdr.slot;

    // Uplink slots are 4, 9, 14 ... 79
    assign slot_uplink = (hdr_slot < cpri_rx_pkg::SLOT_LIMIT) &&
                         ((hdr_slot % cpri_rx_pkg::UPLINK_PERIOD) ==
                          cpri_rx_pkg::UPLINK_PHASE);

    // Decision is taken once on the header, then held for the burst
    assign keep = hdr_cycle ? (slot_uplink & ~i_buf_full) : burst_keep;

    // Index of the arriving word within its burst
    assign word_idx  = hdr_cycle ? '0 : o_wr_addr + 1'b1;
    assign word_last = (word_idx == cpri_rx_pkg::ADDR_W'(cpri_rx_pkg::SYMBOL_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rvalid_q   <= 1'b0;
            burst_keep <= 1'b0;
        end else begin
            rvalid_q   <= i_rvalid;
            burst_keep <= i_rvalid & keep;
        end
    end

    // ------------------------------------------------------------
    // Write strobes, one cycle behind arrival
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_en   <= 1'b0;
            o_wr_done <= 1'b0;
            o_wr_addr <= '0;
        end else begin
            o_wr_en   <= i_rvalid & keep;
            o_wr_done <= i_rvalid & keep & word_last;
            if (i_rvalid) begin
                o_wr_addr <= word_idx;
            end
        end
    end

    // Payload follows the strobe
    always_ff @(posedge i_clk) begin
        o_wr_data <= i_rx_data;
    end

endmodule

/* vlog.f */
verilog/cpri_rx_pkg.sv
verilog/uplink_symbol_writer.sv
verilog/chip_read_sequencer.sv
verilog/symbol_buffer.sv
verilog/cpri_rx_buffer.sv
bench/cpri_rx_buffer_sva.sv
bench/tb_cpri_rx_buffer.sv
